// ==== hdl/pix_pkg.sv ====
`default_nettype none

package pix_pkg;

    // ======================================================================
    // Sensor pixel format
    // ======================================================================
    localparam int PIX_WIDTH = 12;

    typedef logic [PIX_WIDTH-1:0] pix_t;

    // One sample of the parallel sensor bus
    typedef struct packed {
        logic fv;
        logic lv;
        pix_t d;
    } sensor_t;

    // ======================================================================
    // Pixel statistics
    // ======================================================================
    // Top bits that classify a pixel as highlight or shadow
    localparam int STAT_BITS = 7;

    // Column and row counters of the subsample grid
    localparam int GRID_BITS = 2;

    typedef logic [17:0] stat_count_t;

endpackage

`default_nettype wire

// ==== hdl/frame_pkg.sv ====
`default_nettype none

package frame_pkg;
    import pix_pkg::*;

    // ======================================================================
    // Stream words and record layout
    // ======================================================================
    localparam int WORD_WIDTH = 16;
    typedef logic [WORD_WIDTH-1:0] word_t;

    localparam int HEADER_WORDS = 4;
    typedef logic [HEADER_WORDS*WORD_WIDTH-1:0] header_t;

    localparam int CHECKSUM_WORDS = 2;

    // Image store and FIFO sizes
    localparam int STORE_DEPTH = 1024;
    localparam int ADDR_WIDTH = 10;
    typedef logic [ADDR_WIDTH:0] count_t;

    localparam int FIFO_DEPTH = 16;

    typedef struct packed {
        logic  write;
        word_t data;
    } stream_t;

    // ======================================================================
    // Fletcher-32 checksum as two sums or as two record words
    // ======================================================================
    typedef struct packed {
        word_t sum_b;
        word_t sum_a;
    } fletcher_t;

    typedef struct packed {
        word_t hi;
        word_t lo;
    } checksum_words_t;

    typedef union packed {
        fletcher_t       sums;
        checksum_words_t words;
    } checksum_u;

    // ======================================================================
    // Command and status
    // ======================================================================
    typedef struct packed {
        logic    capture_req;
        logic    readout_req;
        header_t header;
    } cmd_t;

    typedef struct packed {
        count_t      word_count;
        stat_count_t highlight_count;
        stat_count_t shadow_count;
    } status_t;

endpackage

`default_nettype wire

// ==== hdl/fletcher_sum.sv ====
`timescale 1ns/100ps
`default_nettype none

module fletcher_sum
    import frame_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  clear,
    input  wire logic  en,
    input  wire word_t din,
    output checksum_u  sum
);

    word_t a_next;

    // Addition modulo 65535 with one conditional subtract
    function automatic word_t mod_add(word_t x, word_t y);
        logic [WORD_WIDTH:0] s;
        logic [WORD_WIDTH:0] m;
        m = {1'b0, {WORD_WIDTH{1'b1}}};
        s = {1'b0, x} + {1'b0, y};
        if (s >= m) begin
            s = s - m;
        end
        return s[WORD_WIDTH-1:0];
    endfunction

    assign a_next = mod_add(sum.sums.sum_a, din);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sum <= '0;
        end else if (clear) begin
            sum <= '0;
        end else if (en) begin
            sum.sums.sum_a <= a_next;
            sum.sums.sum_b <= mod_add(sum.sums.sum_b, a_next);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pixel_stats.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_stats
    import pix_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire logic    clear,
    input  wire sensor_t sensor,
    input  wire logic    active,
    output stat_count_t  highlight_count,
    output stat_count_t  shadow_count
);

    logic [GRID_BITS-1:0] col;
    logic [GRID_BITS-1:0] row;
    logic                 lv_prev;
    logic                 sample;
    pix_t                 sample_pix;

    // Grid position within the frame
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col     <= '0;
            row     <= '0;
            lv_prev <= 1'b0;
            sample  <= 1'b0;
        end else begin
            lv_prev <= sensor.lv;
            col     <= sensor.lv ? col + 1'b1 : '0;
            if (!sensor.fv) begin
                row <= '0;
            end else if (lv_prev && !sensor.lv) begin
                row <= row + 1'b1;
            end
            // Grid hit decided one cycle ahead of the count
            sample <= active && sensor.fv && sensor.lv && (col == '0) && (row == '0);
        end
    end

    always_ff @(posedge clk) begin
        sample_pix <= sensor.d;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (clear) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (sample) begin
            if (&sample_pix[PIX_WIDTH-1 -: STAT_BITS]) begin
                highlight_count <= highlight_count + 1'b1;
            end else if (~|sample_pix[PIX_WIDTH-1 -: STAT_BITS]) begin
                shadow_count <= shadow_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/capture_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module capture_ctrl
    import frame_pkg::*;
(
    input  wire logic clk,
    input  wire logic arst_n,
    input  wire cmd_t cmd,
    output logic      cmd_ack,
    output logic      start_capture,
    output logic      start_readout,
    input  wire logic framer_done,
    input  wire logic fifo_ready,
    input  wire logic readout_done
);

    typedef enum logic [2:0] {
        s_idle,
        s_capturing,
        s_draining,
        s_readout,
        s_ack
    } state_t;

    state_t state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= s_idle;
            cmd_ack       <= 1'b0;
            start_capture <= 1'b0;
            start_readout <= 1'b0;
        end else begin
            start_capture <= 1'b0;
            start_readout <= 1'b0;

            case (state)
                s_idle: begin
                    if (cmd.capture_req) begin
                        start_capture <= 1'b1;
                        state         <= s_capturing;
                    end else if (cmd.readout_req) begin
                        start_readout <= 1'b1;
                        state         <= s_readout;
                    end
                end

                // Framer still producing header, pixels or checksum
                s_capturing: begin
                    if (framer_done) begin
                        state <= s_draining;
                    end
                end

                // Last words still sitting in the FIFO
                s_draining: begin
                    if (!fifo_ready) begin
                        cmd_ack <= 1'b1;
                        state   <= s_ack;
                    end
                end

                s_readout: begin
                    if (readout_done) begin
                        cmd_ack <= 1'b1;
                        state   <= s_ack;
                    end
                end

                // Hold ack until the requester lets go
                s_ack: begin
                    if (!cmd.capture_req && !cmd.readout_req) begin
                        cmd_ack <= 1'b0;
                        state   <= s_idle;
                    end
                end

                default: state <= s_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pixel_framer.sv ====
`timescale 1ns/100ps
`default_nettype none

module pixel_framer
    import pix_pkg::*;
    import frame_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire sensor_t sensor,
    input  wire header_t header,
    input  wire logic    start_capture,
    output stream_t      stream,
    output logic         framer_done,
    output stat_count_t  highlight_count,
    output stat_count_t  shadow_count
);

    typedef enum logic [2:0] {
        s_idle,
        s_header,
        s_wait_low,
        s_wait_high,
        s_pixels,
        s_checksum,
        s_done
    } state_t;

    typedef logic [$clog2(HEADER_WORDS)-1:0] hdr_idx_t;
    typedef logic [$clog2(CHECKSUM_WORDS)-1:0] ck_idx_t;

    state_t    state;
    sensor_t   sen_q;
    header_t   hdr_sr;
    hdr_idx_t  hdr_left;
    ck_idx_t   ck_idx;
    logic      pixel_phase;
    logic      word_en;
    word_t     word_data;
    logic      ck_en;
    word_t     ck_word;
    checksum_u sum;

    // Input register stage for the sensor bus
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sen_q <= '0;
        end else begin
            sen_q <= sensor;
        end
    end

    // ======================================================================
    // Word selection
    // ======================================================================
    assign pixel_phase = (state == s_wait_high) || (state == s_pixels);

    // Header and pixel words feed the checksum
    always_comb begin
        word_en   = 1'b0;
        word_data = {{(WORD_WIDTH-PIX_WIDTH){1'b0}}, sen_q.d};
        if (state == s_header) begin
            word_en   = 1'b1;
            word_data = hdr_sr[$bits(header_t)-1 -: WORD_WIDTH];
        end else if (pixel_phase) begin
            word_en = sen_q.fv && sen_q.lv;
        end
    end

    // First checksum word goes out as soon as fv is seen low
    assign ck_en   = (state == s_checksum) || ((state == s_pixels) && !sen_q.fv);
    assign ck_word = (ck_idx == '0) ? sum.words.hi : sum.words.lo;

    always_ff @(posedge clk) begin
        if (start_capture) begin
            hdr_sr <= header;
        end else if (state == s_header) begin
            hdr_sr <= hdr_sr << WORD_WIDTH;
        end
    end

    // ======================================================================
    // Framing FSM
    // ======================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= s_idle;
            hdr_left    <= '0;
            ck_idx      <= '0;
            stream      <= '0;
            framer_done <= 1'b0;
        end else begin
            framer_done  <= 1'b0;
            stream.write <= word_en || ck_en;
            stream.data  <= ck_en ? ck_word : word_data;
            if (ck_en) begin
                ck_idx <= ck_idx + 1'b1;
            end

            case (state)
                s_header: begin
                    hdr_left <= hdr_left - 1'b1;
                    if (hdr_left == '0) begin
                        state <= s_wait_low;
                    end
                end
                s_wait_low: begin
                    if (!sen_q.fv) begin
                        state <= s_wait_high;
                    end
                end
                s_wait_high: begin
                    if (sen_q.fv) begin
                        state <= s_pixels;
                    end
                end
                s_pixels: begin
                    if (!sen_q.fv) begin
                        state <= s_checksum;
                    end
                end
                s_checksum: begin
                    if (ck_idx == ck_idx_t'(CHECKSUM_WORDS - 1)) begin
                        state <= s_done;
                    end
                end
                s_done: begin
                    framer_done <= 1'b1;
                    state       <= s_idle;
                end
                default: ;
            endcase

            if (start_capture) begin
                state    <= s_header;
                hdr_left <= hdr_idx_t'(HEADER_WORDS - 1);
                ck_idx   <= '0;
            end
        end
    end

    fletcher_sum u_sum (
        .clk    (clk),
        .arst_n (arst_n),
        .clear  (start_capture),
        .en     (word_en),
        .din    (word_data),
        .sum    (sum)
    );

    pixel_stats u_stats (
        .clk             (clk),
        .arst_n          (arst_n),
        .clear           (start_capture),
        .sensor          (sen_q),
        .active          (pixel_phase),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

endmodule

`default_nettype wire

// ==== hdl/stream_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module stream_fifo
    import frame_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire stream_t stream,
    output logic         fifo_ready,
    input  wire logic    fifo_take,
    output word_t        fifo_data
);

    typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(FIFO_DEPTH):0] level_t;

    word_t  mem [FIFO_DEPTH];
    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    level_t count;
    logic   do_write;
    logic   do_read;

    // Writes into a full buffer are dropped
    assign do_write   = stream.write && (count != level_t'(FIFO_DEPTH));
    assign do_read    = fifo_ready && fifo_take;
    assign fifo_ready = (count != '0);
    assign fifo_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr] <= stream.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/image_store.sv ====
`timescale 1ns/100ps
`default_nettype none

module image_store
    import frame_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  start_capture,
    input  wire logic  start_readout,
    input  wire logic  fifo_ready,
    output logic       fifo_take,
    input  wire word_t fifo_data,
    output logic       rd_ready,
    input  wire logic  rd_take,
    output word_t      rd_data,
    output logic       readout_done,
    output count_t     word_count
);

    typedef enum logic [1:0] {
        rd_idle,
        rd_fetch,
        rd_present
    } rd_state_t;

    word_t     mem [STORE_DEPTH];
    rd_state_t rd_state;
    count_t    rd_addr;
    logic      store_word;

    // Words past the end of the store are taken but dropped
    assign store_word = fifo_take && fifo_ready && (word_count < count_t'(STORE_DEPTH));

    // ======================================================================
    // Memory and readout data
    // ======================================================================
    always_ff @(posedge clk) begin
        if (store_word) begin
            mem[word_count[ADDR_WIDTH-1:0]] <= fifo_data;
        end
        if (rd_state == rd_fetch) begin
            rd_data <= mem[rd_addr[ADDR_WIDTH-1:0]];
        end
    end

    // ======================================================================
    // Capture and readout control
    // ======================================================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fifo_take    <= 1'b0;
            word_count   <= '0;
            rd_state     <= rd_idle;
            rd_addr      <= '0;
            rd_ready     <= 1'b0;
            readout_done <= 1'b0;
        end else begin
            readout_done <= 1'b0;

            if (start_capture) begin
                fifo_take  <= 1'b1;
                word_count <= '0;
            end else if (store_word) begin
                word_count <= word_count + 1'b1;
            end

            if (start_readout) begin
                fifo_take <= 1'b0;
                rd_addr   <= '0;
                rd_state  <= rd_fetch;
            end else begin
                case (rd_state)
                    // Memory read happens here, or the record is finished
                    rd_fetch: begin
                        if (rd_addr == word_count) begin
                            readout_done <= 1'b1;
                            rd_state     <= rd_idle;
                        end else begin
                            rd_ready <= 1'b1;
                            rd_state <= rd_present;
                        end
                    end
                    rd_present: begin
                        if (rd_take) begin
                            rd_ready <= 1'b0;
                            rd_addr  <= rd_addr + 1'b1;
                            rd_state <= rd_fetch;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/img_capture_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module img_capture_top
    import pix_pkg::*;
    import frame_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    arst_n,
    input  wire cmd_t    cmd,
    output logic         cmd_ack,
    input  wire sensor_t sensor,
    output logic         rd_ready,
    input  wire logic    rd_take,
    output word_t        rd_data,
    output status_t      status
);

    logic    start_capture;
    logic    start_readout;
    logic    framer_done;
    logic    readout_done;
    logic    fifo_ready;
    logic    fifo_take;
    word_t   fifo_data;
    stream_t stream;

    capture_ctrl u_ctrl (
        .clk           (clk),
        .arst_n        (arst_n),
        .cmd           (cmd),
        .cmd_ack       (cmd_ack),
        .start_capture (start_capture),
        .start_readout (start_readout),
        .framer_done   (framer_done),
        .fifo_ready    (fifo_ready),
        .readout_done  (readout_done)
    );

    pixel_framer u_framer (
        .clk             (clk),
        .arst_n          (arst_n),
        .sensor          (sensor),
        .header          (cmd.header),
        .start_capture   (start_capture),
        .stream          (stream),
        .framer_done     (framer_done),
        .highlight_count (status.highlight_count),
        .shadow_count    (status.shadow_count)
    );

    stream_fifo u_fifo (
        .clk        (clk),
        .arst_n     (arst_n),
        .stream     (stream),
        .fifo_ready (fifo_ready),
        .fifo_take  (fifo_take),
        .fifo_data  (fifo_data)
    );

    image_store u_store (
        .clk           (clk),
        .arst_n        (arst_n),
        .start_capture (start_capture),
        .start_readout (start_readout),
        .fifo_ready    (fifo_ready),
        .fifo_take     (fifo_take),
        .fifo_data     (fifo_data),
        .rd_ready      (rd_ready),
        .rd_take       (rd_take),
        .rd_data       (rd_data),
        .readout_done  (readout_done),
        .word_count    (status.word_count)
    );

endmodule

`default_nettype wire

// ==== dv/tb_img_capture.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_img_capture
    import pix_pkg::*;
    import frame_pkg::*;
();

    // ======================================================================
    // Test parameters and frame table
    // ======================================================================
    localparam int NUM_CASES    = 5;
    localparam int BLANK_CYCLES = 12;
    localparam int ACK_TIMEOUT  = 100;
    localparam int HOLD_CYCLES  = 3;
    localparam int GRID         = 1 << GRID_BITS;

    typedef struct packed {
        header_t header;
        int      lines;
        int      ppl;
        int      gap;
        logic    stall;
    } frame_case_t;

    logic        clk;
    logic        arst_n;
    cmd_t        cmd;
    logic        cmd_ack;
    sensor_t     sensor;
    logic        rd_ready;
    logic        rd_take;
    word_t       rd_data;
    status_t     status;

    frame_case_t cases [NUM_CASES];
    logic [31:0] rng;
    int unsigned sum_a;
    int unsigned sum_b;
    pix_t        frame_pix [$];
    word_t       exp_words [$];
    status_t     exp_status;

    img_capture_top UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .cmd      (cmd),
        .cmd_ack  (cmd_ack),
        .sensor   (sensor),
        .rd_ready (rd_ready),
        .rd_take  (rd_take),
        .rd_data  (rd_data),
        .status   (status)
    );

    always #5 clk = ~clk;

    // ======================================================================
    // Helpers
    // ======================================================================
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_status(input string name, input status_t got, input status_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic expect_no_ack(input string phase);
        if (cmd_ack) begin
            abort_run($sformatf("cmd_ack rose too early during %s", phase));
        end
    endtask

    task automatic wait_for_ack(input logic level, input int limit, input string what);
        int cycles;
        cycles = 0;
        while (cmd_ack !== level) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_run($sformatf("timeout waiting for cmd_ack = %0d after %s", level, what));
            end
        end
    endtask

    // Request stays up for a few cycles and cmd_ack has to stay with it
    task automatic hold_request(input string what);
        int i;
        for (i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk);
            if (cmd_ack !== 1'b1) begin
                abort_run($sformatf("cmd_ack fell before the %s request was dropped", what));
            end
        end
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================
    // Appends one header or pixel word and advances both Fletcher sums
    task automatic add_word(input word_t w);
        exp_words.push_back(w);
        sum_a = (sum_a + 32'(w)) % 65535;
        sum_b = (sum_b + sum_a) % 65535;
    endtask

    task automatic build_record(input frame_case_t fc);
        int                   r;
        int                   c;
        int                   hl;
        int                   sh;
        pix_t                 px;
        logic [STAT_BITS-1:0] top;
        frame_pix.delete();
        exp_words.delete();
        sum_a = 0;
        sum_b = 0;
        hl    = 0;
        sh    = 0;
        for (r = 0; r < HEADER_WORDS; r++) begin
            add_word(fc.header[(HEADER_WORDS-1-r)*WORD_WIDTH +: WORD_WIDTH]);
        end
        for (r = 0; r < fc.lines; r++) begin
            for (c = 0; c < fc.ppl; c++) begin
                rng = xorshift32(rng);
                px  = rng[PIX_WIDTH-1:0];
                // Force some pixels into highlight or shadow range
                case (rng[17:16])
                    2'd0:    px[PIX_WIDTH-1 -: STAT_BITS] = '1;
                    2'd1:    px[PIX_WIDTH-1 -: STAT_BITS] = '0;
                    default: ;
                endcase
                frame_pix.push_back(px);
                add_word(word_t'(px));
                if ((r % GRID == 0) && (c % GRID == 0)) begin
                    top = px[PIX_WIDTH-1 -: STAT_BITS];
                    if (&top) begin
                        hl++;
                    end else if (top == '0) begin
                        sh++;
                    end
                end
            end
        end
        // Sum b goes out first
        exp_words.push_back(word_t'(sum_b));
        exp_words.push_back(word_t'(sum_a));
        exp_status.word_count      = count_t'(exp_words.size());
        exp_status.highlight_count = stat_count_t'(hl);
        exp_status.shadow_count    = stat_count_t'(sh);
    endtask

    // ======================================================================
    // Sensor driver and readout consumer
    // ======================================================================
    task automatic drive_frame(input frame_case_t fc);
        int i;
        int r;
        int c;
        int k;
        k = 0;
        // Blanking with lv noise while fv is low
        for (i = 0; i < BLANK_CYCLES; i++) begin
            @(negedge clk);
            expect_no_ack("blanking");
            rng       = xorshift32(rng);
            sensor.fv = 1'b0;
            sensor.lv = (i < BLANK_CYCLES - 2) ? rng[12] : 1'b0;
            sensor.d  = rng[PIX_WIDTH-1:0];
        end
        // Front porch
        for (i = 0; i < 2; i++) begin
            @(negedge clk);
            expect_no_ack("front porch");
            rng    = xorshift32(rng);
            sensor = '{fv: 1'b1, lv: 1'b0, d: rng[PIX_WIDTH-1:0]};
        end
        for (r = 0; r < fc.lines; r++) begin
            for (c = 0; c < fc.ppl; c++) begin
                @(negedge clk);
                expect_no_ack("frame");
                sensor = '{fv: 1'b1, lv: 1'b1, d: frame_pix[k]};
                k++;
            end
            // Line gap carries junk data that must not be stored
            for (i = 0; i < fc.gap; i++) begin
                @(negedge clk);
                expect_no_ack("line gap");
                rng    = xorshift32(rng);
                sensor = '{fv: 1'b1, lv: 1'b0, d: rng[PIX_WIDTH-1:0]};
            end
        end
        @(negedge clk);
        sensor = '0;
    endtask

    task automatic read_record(input logic stall);
        int   idx;
        int   cycles;
        int   limit;
        int   stall_left;
        logic finished;
        idx        = 0;
        cycles     = 0;
        stall_left = 0;
        finished   = 1'b0;
        limit      = exp_words.size() * 12 + 50;
        while (!finished) begin
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                abort_run("timeout: readout did not end with cmd_ack");
            end
            rd_take = 1'b0;
            if (cmd_ack) begin
                finished = 1'b1;
            end else if (rd_ready) begin
                if (idx >= exp_words.size()) begin
                    abort_run("store presented a word past the end of the record");
                end else begin
                    // Also catches rd_data moving while stalled
                    check_word("rd_data", rd_data, exp_words[idx]);
                    if (stall_left > 0) begin
                        stall_left--;
                    end else begin
                        rd_take = 1'b1;
                        idx++;
                        if (stall) begin
                            rng        = xorshift32(rng);
                            stall_left = int'(rng[2:0]);
                        end
                    end
                end
            end
        end
        check_count("readout word count", count_t'(idx), count_t'(exp_words.size()));
    endtask

    task automatic run_case(input frame_case_t fc);
        build_record(fc);
        @(negedge clk);
        cmd.header      = fc.header;
        cmd.capture_req = 1'b1;
        drive_frame(fc);
        wait_for_ack(1'b1, ACK_TIMEOUT, "capture request");
        check_status("status", status, exp_status);
        hold_request("capture");
        cmd.capture_req = 1'b0;
        wait_for_ack(1'b0, ACK_TIMEOUT, "capture release");

        cmd.readout_req = 1'b1;
        read_record(fc.stall);
        check_status("status", status, exp_status);
        hold_request("readout");
        cmd.readout_req = 1'b0;
        wait_for_ack(1'b0, ACK_TIMEOUT, "readout release");
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        clk     = 1'b0;
        arst_n  = 1'b0;
        cmd     = '0;
        sensor  = '0;
        rd_take = 1'b0;
        rng     = 32'd73;

        // header, lines, pixels per line, line gap, readout stalls
        cases[0] = '{64'h0123_4567_89AB_CDEF, 4, 8, 1, 1'b0};
        cases[1] = '{64'hFFFF_0000_A5A5_5A5A, 6, 13, 3, 1'b1};
        cases[2] = '{64'h0000_0000_0000_0001, 1, 1, 1, 1'b1};
        cases[3] = '{64'hDEAD_BEEF_CAFE_F00D, 9, 20, 2, 1'b1};
        cases[4] = '{64'h8000_7FFF_1234_FEDC, 5, 16, 5, 1'b0};

        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        for (int n = 0; n < NUM_CASES; n++) begin
            run_case(cases[n]);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/pix_pkg.sv
hdl/frame_pkg.sv
hdl/fletcher_sum.sv
hdl/pixel_stats.sv
hdl/capture_ctrl.sv
hdl/pixel_framer.sv
hdl/stream_fifo.sv
hdl/image_store.sv
hdl/img_capture_top.sv
dv/tb_img_capture.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f src.f \
    --top-module tb_img_capture \
    -Mdir obj_dir

# Exit status of the simulation decides pass or fail
./obj_dir/Vtb_img_capture
